// ==== source/perm_pkg.sv ====
`default_nettype none

package perm_pkg;

  // buffer geometry
  // word = E lanes of FSIZE bits
  parameter int E = 4;
  parameter int FSIZE = 16;
  parameter int DATA_W = E * FSIZE;

  // one address per buffer word, 4096 words
  parameter int ADDR_W = 12;

  // source RAM read latency in cycles
  parameter int READ_LATENCY = 2;

  // pattern codes as carried on the start request
  // codes outside 1..12 fall back to PAT_1 in the address map
  typedef enum logic [15:0] {
    PAT_1  = 16'd1,
    PAT_2  = 16'd2,
    PAT_3  = 16'd3,
    PAT_4  = 16'd4,
    PAT_5  = 16'd5,
    PAT_6  = 16'd6,
    PAT_7  = 16'd7,
    PAT_8  = 16'd8,
    PAT_9  = 16'd9,
    PAT_10 = 16'd10,
    PAT_11 = 16'd11,
    PAT_12 = 16'd12
  } perm_pattern_e;

  // sequencer FSM
  // idle: waiting for start
  // read: one source read per cycle
  // drain: waiting for the last write to leave the pipeline
  typedef enum logic [1:0] {
    ST_IDLE  = 2'd0,
    ST_READ  = 2'd1,
    ST_DRAIN = 2'd2
  } perm_state_e;

endpackage

`default_nettype wire

// ==== source/perm_addr_map.sv ====
`timescale 1ns/10ps
`default_nettype none

module perm_addr_map #(
  parameter int ADDR_W = perm_pkg::ADDR_W
) (
  input  perm_pkg::perm_pattern_e pattern,
  input  logic [ADDR_W-1:0]       addr,
  output logic [ADDR_W-1:0]       mapped_addr
);

  import perm_pkg::*;

  // the bit tables below are written for 12-bit addresses only
  if (ADDR_W != 12) begin : g_width_check
    $error("perm_addr_map needs ADDR_W of 12, got %0d", ADDR_W);
  end

  // pure wiring, no pipeline stage
  // each entry is written msb first
  // source bit order per pattern, listed for output bit 0 upward
  always_comb begin
    case (pattern)
      // out 0..11 <- 3 4 5 6 7 8 0 1 2 9 10 11
      // low six bits rotate past the next three
      PAT_2, PAT_8: begin
        mapped_addr = {addr[11:9], addr[2:0], addr[8:3]};
      end

      // out 0..11 <- 8 9 10 0 1 2 3 4 5 6 7 11
      // msb stays put
      PAT_3: begin
        mapped_addr = {addr[11], addr[7:0], addr[10:8]};
      end

      // out 0..11 <- 11 0 1 2 ... 10
      // rotate left by one
      PAT_4: begin
        mapped_addr = {addr[10:0], addr[11]};
      end

      // out 0..11 <- 3 4 ... 11 0 1 2
      // full rotate right by three
      PAT_5, PAT_11: begin
        mapped_addr = {addr[2:0], addr[11:3]};
      end

      // out 0..11 <- 3 4 ... 10 0 1 2 11
      // rotate right by three on the low eleven bits
      PAT_6: begin
        mapped_addr = {addr[11], addr[2:0], addr[10:3]};
      end

      // out 0..11 <- 4 0 1 5 6 7 8 9 10 11 2 3
      PAT_7: begin
        mapped_addr = {addr[3:2], addr[11:5], addr[1:0], addr[4]};
      end

      // out 0..11 <- 7 8 9 0 1 2 3 4 5 6 10 11
      // two top bits untouched
      PAT_9: begin
        mapped_addr = {addr[11:10], addr[6:0], addr[9:7]};
      end

      // out 0..11 <- 10 11 0 1 ... 9
      // rotate left by two
      PAT_10: begin
        mapped_addr = {addr[9:0], addr[11:10]};
      end

      // out 0..11 <- 3 4 5 6 7 8 9 0 1 2 10 11
      PAT_12: begin
        mapped_addr = {addr[11:10], addr[2:0], addr[9:3]};
      end

      // PAT_1 and every unlisted code
      // out 0..11 <- 2 3 0 4 5 6 7 8 9 10 11 1
      default: begin
        mapped_addr = {addr[1], addr[11:4], addr[0], addr[3:2]};
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== source/perm_delay_line.sv ====
`timescale 1ns/10ps
`default_nettype none

module perm_delay_line #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 1
) (
  input  logic             clk,
  input  logic             rstn,
  input  logic             in_valid,
  input  logic [WIDTH-1:0] in_data,
  output logic             out_valid,
  output logic [WIDTH-1:0] out_data
);

  if (DEPTH < 1) begin : g_depth_check
    $error("perm_delay_line needs DEPTH of at least 1, got %0d", DEPTH);
  end

  // stage 0 is fed from the input, stage DEPTH-1 drives the output
  logic [DEPTH-1:0] valid_q;
  logic [WIDTH-1:0] data_q [DEPTH];

  // valid chain, cleared on reset
  always_ff @(posedge clk) begin
    if (!rstn) begin
      valid_q <= '0;
    end else begin
      valid_q[0] <= in_valid;
      for (int i = 1; i < DEPTH; i++) begin
        valid_q[i] <= valid_q[i-1];
      end
    end
  end

  // payload chain, free running
  always_ff @(posedge clk) begin
    data_q[0] <= in_data;
    for (int i = 1; i < DEPTH; i++) begin
      data_q[i] <= data_q[i-1];
    end
  end

  assign out_valid = valid_q[DEPTH-1];
  assign out_data  = data_q[DEPTH-1];

endmodule

`default_nettype wire

// ==== source/perm_sequencer.sv ====
`timescale 1ns/10ps
`default_nettype none

module perm_sequencer #(
  parameter int ADDR_W       = perm_pkg::ADDR_W,
  parameter int READ_LATENCY = perm_pkg::READ_LATENCY
) (
  input  logic                    clk,
  input  logic                    rstn,
  input  logic                    start_valid,
  input  perm_pkg::perm_pattern_e start_pattern,
  output logic                    start_ready,
  output perm_pkg::perm_pattern_e pattern,
  output logic [ADDR_W-1:0]       rd_addr,
  output logic                    rd_valid,
  output logic                    rd_last,
  output logic                    busy
);

  import perm_pkg::*;

  // drain lasts READ_LATENCY+1 cycles, counter runs 0..READ_LATENCY
  localparam int DRAIN_W = $clog2(READ_LATENCY + 2);
  localparam logic [DRAIN_W-1:0] DRAIN_END = DRAIN_W'(READ_LATENCY);
  localparam logic [ADDR_W-1:0] LAST_ADDR = '1;

  perm_state_e state;
  perm_state_e state_next;

  // read counter doubles as the source RAM address
  logic [ADDR_W-1:0]  rd_cnt;
  logic [DRAIN_W-1:0] drain_cnt;
  logic               start_fire;

  // handshake only in idle
  assign start_ready = (state == ST_IDLE);
  assign start_fire  = start_valid && start_ready;
  assign busy        = (state != ST_IDLE);

  // one read per cycle while in read state
  assign rd_valid = (state == ST_READ);
  assign rd_addr  = rd_cnt;
  assign rd_last  = rd_valid && (rd_cnt == LAST_ADDR);

  always_comb begin
    state_next = state;
    case (state)
      ST_IDLE: begin
        if (start_fire) begin
          state_next = ST_READ;
        end
      end
      // leave right after the last address went out
      ST_READ: begin
        if (rd_last) begin
          state_next = ST_DRAIN;
        end
      end
      // last write leaves the pipe in the final drain cycle
      ST_DRAIN: begin
        if (drain_cnt == DRAIN_END) begin
          state_next = ST_IDLE;
        end
      end
      default: begin
        state_next = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state <= ST_IDLE;
    end else begin
      state <= state_next;
    end
  end

  // counters
  always_ff @(posedge clk) begin
    if (!rstn) begin
      rd_cnt    <= '0;
      drain_cnt <= '0;
    end else begin
      if (start_fire) begin
        rd_cnt <= '0;
      end else if (rd_valid) begin
        // wraps to zero after the last address
        rd_cnt <= rd_cnt + 1'b1;
      end
      if (state == ST_DRAIN) begin
        drain_cnt <= drain_cnt + 1'b1;
      end else begin
        drain_cnt <= '0;
      end
    end
  end

  // pattern held for the whole run, until the next start
  always_ff @(posedge clk) begin
    if (start_fire) begin
      pattern <= start_pattern;
    end
  end

  // every run sweeps from address zero
  a_read_from_zero: assert property (@(posedge clk) disable iff (!rstn)
    $rose(rd_valid) |-> (rd_addr == '0));

  // a latched X pattern would scramble the whole run
  a_pattern_known: assert property (@(posedge clk) disable iff (!rstn)
    start_fire |-> !$isunknown(start_pattern));

endmodule

`default_nettype wire

// ==== source/perm_engine.sv ====
`timescale 1ns/10ps
`default_nettype none

module perm_engine #(
  parameter int ADDR_W       = perm_pkg::ADDR_W,
  parameter int DATA_W       = perm_pkg::DATA_W,
  parameter int READ_LATENCY = perm_pkg::READ_LATENCY
) (
  input  logic                    clk,
  input  logic                    rstn,
  input  logic                    start_valid,
  input  perm_pkg::perm_pattern_e start_pattern,
  output logic                    start_ready,
  output logic [ADDR_W-1:0]       rd_addr,
  input  logic [DATA_W-1:0]       rd_data,
  output logic                    wr_en,
  output logic [ADDR_W-1:0]       wr_addr,
  output logic [DATA_W-1:0]       wr_data,
  output logic                    busy
);

  import perm_pkg::*;

  perm_pattern_e     pattern;
  logic              rd_valid;
  logic              rd_last;
  logic [ADDR_W-1:0] mapped_addr;

  // address side payload is {last, mapped address}
  logic [ADDR_W:0]   addr_dly_in;
  logic [ADDR_W:0]   addr_dly_out;
  logic              addr_valid;
  logic              wr_last;

  perm_sequencer #(
    .ADDR_W       (ADDR_W),
    .READ_LATENCY (READ_LATENCY)
  ) u_seq (
    .clk           (clk),
    .rstn          (rstn),
    .start_valid   (start_valid),
    .start_pattern (start_pattern),
    .start_ready   (start_ready),
    .pattern       (pattern),
    .rd_addr       (rd_addr),
    .rd_valid      (rd_valid),
    .rd_last       (rd_last),
    .busy          (busy)
  );

  perm_addr_map #(
    .ADDR_W (ADDR_W)
  ) u_map (
    .pattern     (pattern),
    .addr        (rd_addr),
    .mapped_addr (mapped_addr)
  );

  assign addr_dly_in = {rd_last, mapped_addr};

  // RAM latency plus the data output register
  perm_delay_line #(
    .WIDTH (ADDR_W + 1),
    .DEPTH (READ_LATENCY + 1)
  ) u_addr_dly (
    .clk       (clk),
    .rstn      (rstn),
    .in_valid  (rd_valid),
    .in_data   (addr_dly_in),
    .out_valid (addr_valid),
    .out_data  (addr_dly_out)
  );

  // rd_data is sampled every cycle
  perm_delay_line #(
    .WIDTH (DATA_W),
    .DEPTH (1)
  ) u_data_dly (
    .clk       (clk),
    .rstn      (rstn),
    .in_valid  (1'b1),
    .in_data   (rd_data),
    .out_valid (),
    .out_data  (wr_data)
  );

  assign wr_last = addr_dly_out[ADDR_W];
  assign wr_addr = addr_dly_out[ADDR_W-1:0];
  assign wr_en   = addr_valid;

  // busy drops right after the final write
  a_busy_falls: assert property (@(posedge clk) disable iff (!rstn)
    wr_en && wr_last |=> !busy);

endmodule

`default_nettype wire

// ==== include/perm_ref_model.svh ====
`ifndef PERM_REF_MODEL_SVH
`define PERM_REF_MODEL_SVH

// source and destination buffer models
logic [perm_pkg::DATA_W-1:0] src_mem [2**perm_pkg::ADDR_W];
logic [perm_pkg::DATA_W-1:0] dst_mem [2**perm_pkg::ADDR_W];

// write count per destination address, one run
int unsigned dst_hits [2**perm_pkg::ADDR_W];

// 32-bit xorshift, never feed it zero
function automatic logic [31:0] xorshift32(input logic [31:0] x);
  logic [31:0] y;
  y = x;
  y = y ^ (y << 13);
  y = y ^ (y >> 17);
  y = y ^ (y << 5);
  return y;
endfunction

// expected destination address for a source address
// table lists the source bit for output bits 0..11
function automatic logic [11:0] ref_map(input logic [15:0] code, input logic [11:0] a);
  int sel [12];
  logic [11:0] m;
  case (code)
    16'd2, 16'd8:  sel = '{3, 4, 5, 6, 7, 8, 0, 1, 2, 9, 10, 11};
    16'd3:         sel = '{8, 9, 10, 0, 1, 2, 3, 4, 5, 6, 7, 11};
    16'd4:         sel = '{11, 0, 1, 2, 3, 4, 5, 6, 7, 8, 9, 10};
    16'd5, 16'd11: sel = '{3, 4, 5, 6, 7, 8, 9, 10, 11, 0, 1, 2};
    16'd6:         sel = '{3, 4, 5, 6, 7, 8, 9, 10, 0, 1, 2, 11};
    16'd7:         sel = '{4, 0, 1, 5, 6, 7, 8, 9, 10, 11, 2, 3};
    16'd9:         sel = '{7, 8, 9, 0, 1, 2, 3, 4, 5, 6, 10, 11};
    16'd10:        sel = '{10, 11, 0, 1, 2, 3, 4, 5, 6, 7, 8, 9};
    16'd12:        sel = '{3, 4, 5, 6, 7, 8, 9, 0, 1, 2, 10, 11};
    // code 1 and anything unlisted
    default:       sel = '{2, 3, 0, 4, 5, 6, 7, 8, 9, 10, 11, 1};
  endcase
  for (int i = 0; i < 12; i++) begin
    m[i] = a[sel[i]];
  end
  return m;
endfunction

`endif

// ==== verification/perm_engine_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module perm_engine_tb;

  import perm_pkg::*;

  localparam int ADDR_W       = perm_pkg::ADDR_W;
  localparam int DATA_W       = perm_pkg::DATA_W;
  localparam int READ_LATENCY = perm_pkg::READ_LATENCY;
  localparam int N            = 2 ** ADDR_W;
  // codes 1..12, code 0, one random high code, one held-valid pair
  localparam int NUM_RUNS     = 16;
  localparam int CLK_NS       = 40;
  localparam longint TIMEOUT_NS = longint'(NUM_RUNS * (N + 20) + 8) * CLK_NS;

  `include "perm_ref_model.svh"

  logic              clk;
  logic              rstn;
  logic              start_valid;
  perm_pattern_e     start_pattern;
  logic              start_ready;
  logic [ADDR_W-1:0] rd_addr;
  logic [DATA_W-1:0] rd_data;
  logic              wr_en;
  logic [ADDR_W-1:0] wr_addr;
  logic [DATA_W-1:0] wr_data;
  logic              busy;

  // rng and monitor state
  logic [31:0]       rng_state;
  int                cyc;
  int                hs_cyc;
  int                rel;
  int                k;
  logic              run_active;
  logic              exp_busy;
  logic              exp_wr;
  logic [15:0]       run_pat;
  logic [ADDR_W-1:0] addr_hist [READ_LATENCY+1];

  perm_engine #(
    .ADDR_W       (ADDR_W),
    .DATA_W       (DATA_W),
    .READ_LATENCY (READ_LATENCY)
  ) u_perm_engine (
    .clk           (clk),
    .rstn          (rstn),
    .start_valid   (start_valid),
    .start_pattern (start_pattern),
    .start_ready   (start_ready),
    .rd_addr       (rd_addr),
    .rd_data       (rd_data),
    .wr_en         (wr_en),
    .wr_addr       (wr_addr),
    .wr_data       (wr_data),
    .busy          (busy)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  function automatic logic [31:0] draw_random();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  task automatic report_failure(input string msg);
    $display("[ERROR] %0t ns: %s", $time, msg);
    $display("Checks failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_addr(input string what, input logic [ADDR_W-1:0] got,
                            input logic [ADDR_W-1:0] exp);
    if (got !== exp) begin
      report_failure($sformatf("%s is %h, expected %h", what, got, exp));
    end
  endtask

  task automatic check_data(input string what, input logic [DATA_W-1:0] got,
                            input logic [DATA_W-1:0] exp);
    if (got !== exp) begin
      report_failure($sformatf("%s is %h, expected %h", what, got, exp));
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      report_failure($sformatf("%s is %b, expected %b", what, got, exp));
    end
  endtask

  // whole destination buffer after a run: each address once, permuted source
  task automatic verify_buffer(input logic [15:0] code);
    logic [ADDR_W-1:0] dst;
    for (int a = 0; a < N; a++) begin
      if (dst_hits[a] != 1) begin
        report_failure($sformatf("destination %0d written %0d times", a, dst_hits[a]));
      end
      dst = ref_map(code, ADDR_W'(a));
      check_data("destination word", dst_mem[dst], src_mem[a]);
    end
  endtask

  // source RAM, data for the address seen READ_LATENCY cycles earlier
  always @(posedge clk) begin
    #2;
    for (int i = READ_LATENCY; i > 0; i--) begin
      addr_hist[i] = addr_hist[i-1];
    end
    addr_hist[0] = rd_addr;
    rd_data = src_mem[addr_hist[READ_LATENCY]];
  end

  // mid-cycle monitor, all DUT outputs settled
  always @(negedge clk) begin
    if (rstn) begin
      // rel 0 is the cycle after the handshake edge
      rel      = cyc - (hs_cyc + 1);
      exp_busy = run_active && (rel <= N + READ_LATENCY);
      exp_wr   = run_active && (rel >= READ_LATENCY + 1) && (rel <= N + READ_LATENCY);
      check_flag("busy", busy, exp_busy);
      check_flag("start_ready", start_ready, !exp_busy);
      check_flag("wr_en", wr_en, exp_wr);
      // ascending reads, one per cycle
      if (run_active && rel < N) begin
        check_addr("rd_addr", rd_addr, ADDR_W'(rel));
      end
      // write k trails read k by READ_LATENCY+1
      if (exp_wr) begin
        k = rel - READ_LATENCY - 1;
        check_addr("wr_addr", wr_addr, ref_map(run_pat, ADDR_W'(k)));
        check_data("wr_data", wr_data, src_mem[k]);
        dst_mem[wr_addr] = wr_data;
        dst_hits[wr_addr]++;
      end
      if (run_active && rel == N + READ_LATENCY + 1) begin
        verify_buffer(run_pat);
        run_active = 1'b0;
      end
      // handshake on the coming edge
      if (start_valid && start_ready) begin
        run_active = 1'b1;
        hs_cyc     = cyc;
        run_pat    = start_pattern;
        for (int a = 0; a < N; a++) begin
          dst_hits[a] = 0;
          dst_mem[a]  = 'x;
        end
      end
    end
  end

  // one start, then wait for the run to drain
  task automatic run_start(input logic [15:0] code);
    start_valid   = 1'b1;
    start_pattern = perm_pattern_e'(code);
    do @(negedge clk); while (!start_ready);
    @(posedge clk);
    #2;
    start_valid = 1'b0;
    do @(negedge clk); while (busy);
    @(posedge clk);
    #2;
  endtask

  // valid stays high through the first run with a new code behind it
  task automatic held_start(input logic [15:0] first, input logic [15:0] second);
    start_valid   = 1'b1;
    start_pattern = perm_pattern_e'(first);
    do @(negedge clk); while (!start_ready);
    @(posedge clk);
    #2;
    start_pattern = perm_pattern_e'(second);
    do @(negedge clk); while (!start_ready);
    @(posedge clk);
    #2;
    start_valid = 1'b0;
    do @(negedge clk); while (busy);
    @(posedge clk);
    #2;
  endtask

  task automatic idle_gap();
    repeat (draw_random() % 8) begin
      @(posedge clk);
      #2;
    end
  endtask

  initial begin
    rng_state     = 32'h7d0e;
    cyc           = 0;
    hs_cyc        = 0;
    run_active    = 1'b0;
    rstn          = 1'b0;
    start_valid   = 1'b0;
    start_pattern = PAT_1;
    rd_data       = '0;
    for (int i = 0; i <= READ_LATENCY; i++) begin
      addr_hist[i] = '0;
    end
    for (int a = 0; a < N; a++) begin
      src_mem[a]  = {draw_random(), draw_random()};
      dst_hits[a] = 0;
    end
    repeat (8) @(posedge clk);
    #2;
    rstn = 1'b1;
    // quiet after reset, the monitor expects ready high and no activity
    repeat (5) @(posedge clk);
    #2;
    for (int code = 1; code <= 12; code++) begin
      run_start(16'(code));
      idle_gap();
    end
    // unlisted codes fall back to PAT_1
    run_start(16'd0);
    idle_gap();
    run_start(16'(13 + draw_random() % (65536 - 13)));
    idle_gap();
    held_start(16'd5, 16'd9);
    repeat (4) @(posedge clk);
    $display("All checks passed");
    $finish;
  end

  // watchdog, every run plus slack and the reset time
  initial begin
    #(TIMEOUT_NS);
    $display("timeout: the engine did not finish all runs in %0d ns", TIMEOUT_NS);
    $display("Checks failed");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+include
source/perm_pkg.sv
source/perm_addr_map.sv
source/perm_delay_line.sv
source/perm_sequencer.sv
source/perm_engine.sv
verification/perm_engine_tb.sv
